/* bench/cache_tests.txt */
# name op addr wdata expected cycles
# op is R or W, values in hex, cycles counted from the request to done
cold_read      R 0100 0000 a4a5 9
cold_write     W 0208 1234 1234 9
read_back      R 0208 0000 1234 2
same_line_w1   R 0102 0000 a4a7 2
same_line_w3   R 0106 0000 a4a3 2
write_hit      W 0104 5a5a 5a5a 2
read_hit       R 0104 0000 5a5a 2
write_line_a   W 0310 beef beef 9
read_line_b    R 0b10 0000 aeb5 13
read_line_a    R 0310 0000 beef 9
read_a_word2   R 0314 0000 a6b1 2
write_dirty    W 0904 7777 7777 13
read_evicted   R 0104 0000 5a5a 13
read_wb_word   R 0904 0000 7777 9
odd_address    R 0107 0000 a4a3 9
top_tag_read   R f800 0000 5da5 9
top_write      W fffe cafe cafe 9
top_read       R fffe 0000 cafe 2

/* verilog.f */
+incdir+src
src/cache_pkg.sv
src/mem_pkg.sv
src/line_store.sv
src/cache_array.sv
src/banked_memory.sv
src/cache_controller.sv
src/cache_system.sv
bench/cache_system_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module cache_system_tb \
	-o cache_sim > build.log 2>&1 \
	&& ./obj_dir/cache_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -qx "Simulation finished: PASS" sim.log && echo "Result: passed" \
	|| { echo "Result: failed"; exit 1; }

/* bench/cache_system_tb.sv */
`include "cache_settings.svh"

module cache_system_tb;

	localparam int RANDOM_OPS   = 40;
	localparam int ACCESS_LIMIT = 20; // Longest access is a dirty miss of 13 cycles

	logic               clk;
	logic               rst_n;
	logic [`ADDR_W-1:0] addr_in;
	logic [`WORD_W-1:0] data_in;
	logic               rd_in;
	logic               wr_in;
	logic [`WORD_W-1:0] data_out;
	logic               done;
	logic               err;

	logic [`WORD_W-1:0] model [1 << (`ADDR_W-1)]; // Flat memory, one entry per word
	string              names [$];
	logic               is_wrs [$];
	logic [`ADDR_W-1:0] addrs [$];
	logic [`WORD_W-1:0] wdatas [$];
	logic [`WORD_W-1:0] expects [$];
	int                 lats [$];
	int                 total_tests = 0;
	int                 run = 0;
	int                 failed = 0;

	cache_system cache_system_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.addr_in  (addr_in),
		.data_in  (data_in),
		.rd_in    (rd_in),
		.wr_in    (wr_in),
		.data_out (data_out),
		.done     (done),
		.err      (err)
	);

	always #5 clk = ~clk;

	task automatic load_tests(output logic ok);
		int                 fd;
		int                 code;
		logic [8*100-1:0]   line_buf;
		logic [8*24-1:0]    name_buf;
		logic [7:0]         op;
		logic [`ADDR_W-1:0] a;
		logic [`WORD_W-1:0] wd;
		logic [`WORD_W-1:0] ed;
		int                 lat;
		fd = $fopen("bench/cache_tests.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			forever begin
				line_buf = '0;
				code = $fgets(line_buf, fd);
				if (code == 0) break;
				code = $sscanf(line_buf, "%s %c %h %h %h %d", name_buf, op, a, wd, ed, lat);
				if (code == 6) begin // Comment and blank lines never give six fields
					names.push_back($sformatf("%0s", name_buf));
					is_wrs.push_back(op == "W");
					addrs.push_back(a);
					wdatas.push_back(wd);
					expects.push_back(ed);
					lats.push_back(lat);
				end
			end
			$fclose(fd);
		end
	endtask

	// One host access, held until done, then one idle cycle back in Idle
	task automatic run_test(input string name, input logic is_wr, input logic [`ADDR_W-1:0] a,
			input logic [`WORD_W-1:0] wd, input logic [`WORD_W-1:0] exp_data,
			input int exp_cycles);
		logic [`WORD_W-1:0] got;
		int                 cycles;
		logic               got_done;
		logic               saw_err;
		logic               bad;
		got      = '0;
		cycles   = 0;
		got_done = 1'b0;
		saw_err  = 1'b0;
		bad      = 1'b0;
		addr_in  = a;
		data_in  = wd;
		rd_in    = ~is_wr;
		wr_in    = is_wr;
		while (!got_done && cycles < ACCESS_LIMIT) begin
			@(posedge clk);
			#1;
			cycles++;
			saw_err = saw_err | err;
			if (done) begin
				got_done = 1'b1;
				got      = data_out;
			end
		end
		rd_in = 1'b0;
		wr_in = 1'b0;
		@(posedge clk);
		#1;
		saw_err = saw_err | err;
		assert (got_done) else begin
			$display("%0s: no done within %0d cycles", name, ACCESS_LIMIT);
			bad = 1'b1;
		end
		if (got_done) begin
			assert (got == exp_data) else begin
				$display("ERR %0s expected %h actual %h", name, exp_data, got);
				bad = 1'b1;
			end
			if (exp_cycles > 0) begin
				assert (cycles == exp_cycles) else begin
					$display("ERR %0s cycles expected %0d actual %0d", name, exp_cycles, cycles);
					bad = 1'b1;
				end
			end
			assert (!done) else begin
				$display("%0s: done stayed high for more than one cycle", name);
				bad = 1'b1;
			end
		end
		assert (!saw_err) else begin
			$display("%0s: err went high during the access", name);
			bad = 1'b1;
		end
		if (is_wr) begin
			model[a[`ADDR_W-1:1]] = wd;
		end
		run++;
		if (bad) failed++;
		$display("test %0s %0s", name, bad ? "failed" : "ok");
	endtask

	initial begin
		logic               ok;
		logic [31:0]        r;
		logic [`ADDR_W-1:0] a;
		clk     = 1'b0;
		rst_n   = 1'b0;
		addr_in = '0;
		data_in = '0;
		rd_in   = 1'b0;
		wr_in   = 1'b0;
		void'($urandom(4655));
		for (int i = 0; i < (1 << (`ADDR_W-1)); i++) begin
			model[i] = {i[`ADDR_W-2:0], 1'b0} ^ 16'hA5A5; // Byte address XOR pattern
		end
		load_tests(ok);
		if (!ok) begin
			$display("Could not open the test vector file bench/cache_tests.txt");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			total_tests = names.size() + RANDOM_OPS;
			repeat (2) @(posedge clk);
			#1;
			rst_n = 1'b1;
			assert (!done && !err) else begin
				$display("ERR after_reset expected done=0 err=0 actual done=%b err=%b", done, err);
				failed++;
			end
			for (int i = 0; i < names.size(); i++) begin
				run_test(names[i], is_wrs[i], addrs[i], wdatas[i], expects[i], lats[i]);
			end
			// Tags 8 to 11 on indexes 0x18 to 0x1b force evictions
			for (int i = 0; i < RANDOM_OPS; i++) begin
				r = $urandom;
				a = {3'b010, r[2:1], 6'b000110, r[4:3], r[6:5], 1'b0};
				run_test($sformatf("random_%0d", i), r[7], a, r[31:16],
					r[7] ? r[31:16] : model[a[`ADDR_W-1:1]], 0);
			end
			$display("%0d tests run, %0d failed", run, failed);
			if (failed == 0) begin
				$display("Simulation finished: PASS");
			end else begin
				$display("Simulation finished: FAIL");
			end
			$finish;
		end
	end

	initial begin
		wait (total_tests > 0);
		repeat (20 * total_tests + 10) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", 20 * total_tests);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* src/cache_system.sv */
`include "cache_settings.svh"

module cache_system (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`ADDR_W-1:0] addr_in,
	input  logic [`WORD_W-1:0] data_in,
	input  logic               rd_in,
	input  logic               wr_in,
	output logic [`WORD_W-1:0] data_out,
	output logic               done,
	output logic               err
);
	import cache_pkg::*;
	import mem_pkg::*;

	logic [`ADDR_W-1:0]      addr;
	cache_ctrl_t             ctrl;
	cache_status_t           status;
	mem_cmd_t                mem_req;
	logic [`LINE_ADDR_W-1:0] line_addr;
	logic [`WORD_W-1:0]      mem_rdata;

	assign data_out = status.data; // Valid while done is high

	cache_controller cache_controller_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_in   (rd_in),
		.wr_in   (wr_in),
		.addr_in (addr_in),
		.status  (status),
		.addr    (addr),
		.ctrl    (ctrl),
		.mem_req (mem_req),
		.done    (done),
		.err     (err)
	);

	cache_array cache_array_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.data_in   (data_in),
		.fill_data (mem_rdata),
		.ctrl      (ctrl),
		.status    (status),
		.line_addr (line_addr)
	);

	banked_memory banked_memory_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (mem_req),
		.line_addr (line_addr),
		.wdata     (status.data), // Victim word during writeback
		.rdata     (mem_rdata)
	);

endmodule

/* src/cache_controller.sv */
`include "cache_settings.svh"

module cache_controller (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     rd_in,
	input  logic                     wr_in,
	input  logic [`ADDR_W-1:0]       addr_in,
	input  cache_pkg::cache_status_t status,
	output logic [`ADDR_W-1:0]       addr,
	output cache_pkg::cache_ctrl_t   ctrl,
	output mem_pkg::mem_cmd_t        mem_req,
	output logic                     done,
	output logic                     err
);
	import cache_pkg::*;
	import mem_pkg::*;

	ctrl_state_t          state;
	ctrl_state_t          state_d;
	logic                 state_bad;
	logic                 accept;
	logic                 op_wr;   // Latched operation, write when set
	logic [`ADDR_W-1:0]   addr_d;
	cache_ctrl_t          ctrl_d;
	mem_cmd_t             cmd_d;
	logic                 done_d;

	assign accept = (state == S_IDLE);
	assign addr_d = accept ? addr_in : addr; // Address held after Idle

	always_comb begin
		state_d   = S_IDLE;
		state_bad = 1'b0;
		case (state)
			S_IDLE: begin
				if (rd_in ^ wr_in) begin
					state_d = wr_in ? S_CMP_WR : S_CMP_RD;
				end
			end
			S_CMP_RD, S_CMP_WR: begin
				if (status.hit & status.valid) begin
					state_d = S_DONE;
				end else if (~status.hit & status.valid & status.dirty) begin
					state_d = S_ACC_RD0; // Victim must be written back
				end else begin
					state_d = S_REQ0;
				end
			end
			S_ACC_RD0:  state_d = S_ACC_RD1;
			S_ACC_RD1:  state_d = S_ACC_RD2;
			S_ACC_RD2:  state_d = S_ACC_RD3;
			S_ACC_RD3:  state_d = S_REQ0;
			S_REQ0:     state_d = S_REQ1;
			S_REQ1:     state_d = S_REQ2_WR0;
			S_REQ2_WR0: state_d = S_REQ3_WR1;
			S_REQ3_WR1: state_d = S_ACC_WR2;
			S_ACC_WR2:  state_d = S_ACC_WR3;
			S_ACC_WR3:  state_d = op_wr ? S_CMP_WR : S_CMP_RD; // Retry the access
			S_DONE:     state_d = S_IDLE;
			default: begin
				state_bad = 1'b1;
				state_d   = S_IDLE;
			end
		endcase
	end

	// Outputs decoded from the next state so they line up with it once registered
	always_comb begin
		ctrl_d = '0;
		cmd_d  = '0;
		done_d = 1'b0;
		ctrl_d.enable = (state_d != S_IDLE);
		if (state_d == S_CMP_RD || state_d == S_CMP_WR) begin
			ctrl_d.comp   = 1'b1;
			ctrl_d.write  = (state_d == S_CMP_WR);
			ctrl_d.offset = addr_d[`OFFSET_W-1:0];
		end
		if (state_d inside {[S_ACC_RD0:S_ACC_RD3]}) begin
			ctrl_d.tag_src = 1'b1; // Victim line address
			ctrl_d.offset  = {2'(state_d - S_ACC_RD0), 1'b0};
			cmd_d.wr       = 1'b1;
			cmd_d.offset   = {2'(state_d - S_ACC_RD0), 1'b0};
		end
		if (state_d inside {[S_REQ0:S_REQ3_WR1]}) begin
			cmd_d.rd     = 1'b1;
			cmd_d.offset = {2'(state_d - S_REQ0), 1'b0};
		end
		if (state_d inside {[S_REQ2_WR0:S_ACC_WR3]}) begin
			ctrl_d.write    = 1'b1; // Fill word arrives two states after its request
			ctrl_d.data_src = 1'b1;
			ctrl_d.offset   = {2'(state_d - S_REQ2_WR0), 1'b0};
		end
		if (state_d == S_DONE) begin
			ctrl_d.offset = addr_d[`OFFSET_W-1:0]; // Keeps data_out on the word
			done_d        = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			addr    <= '0;
			op_wr   <= 1'b0;
			ctrl    <= '0;
			mem_req <= '0;
			done    <= 1'b0;
			err     <= 1'b0;
		end else begin
			state   <= state_d;
			addr    <= addr_d;
			ctrl    <= ctrl_d;
			mem_req <= cmd_d;
			done    <= done_d;
			err     <= state_bad; // Flags an encoding outside the 14 states
			if (accept) begin
				op_wr <= wr_in;
			end
		end
	end

endmodule

/* src/banked_memory.sv */
`include "cache_settings.svh"

module banked_memory (
	input  logic                    clk,
	input  logic                    rst_n,
	input  mem_pkg::mem_cmd_t       cmd,
	input  logic [`LINE_ADDR_W-1:0] line_addr,
	input  logic [`WORD_W-1:0]      wdata,
	output logic [`WORD_W-1:0]      rdata
);
	import mem_pkg::*;

	localparam int BANK_DEPTH = 1 << `LINE_ADDR_W;
	localparam int BANK_W     = $clog2(NUM_BANKS);

	logic [`WORD_W-1:0] bank [NUM_BANKS][BANK_DEPTH];
	logic [`WORD_W-1:0] rd_pipe [`MEM_LATENCY];
	logic [BANK_W-1:0]  bank_sel;

	assign bank_sel = cmd.offset[2:1];
	assign rdata    = rd_pipe[`MEM_LATENCY-1]; // Word requested MEM_LATENCY cycles ago

	// Reset loads a known pattern so misses return predictable data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				for (int i = 0; i < BANK_DEPTH; i++) begin
					bank[b][i] <= {i[`LINE_ADDR_W-1:0], b[BANK_W-1:0], 1'b0} ^ `MEM_INIT_KEY;
				end
			end
		end else if (cmd.wr) begin
			bank[bank_sel][line_addr] <= wdata; // Lands on the request edge
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.rd) begin
			rd_pipe[0] <= bank[bank_sel][line_addr];
		end
		for (int s = 1; s < `MEM_LATENCY; s++) begin
			rd_pipe[s] <= rd_pipe[s-1]; // Later stages just shift
		end
	end

endmodule

/* src/cache_array.sv */
`include "cache_settings.svh"

module cache_array (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`ADDR_W-1:0]       addr,
	input  logic [`WORD_W-1:0]       data_in,
	input  logic [`WORD_W-1:0]       fill_data,
	input  cache_pkg::cache_ctrl_t   ctrl,
	output cache_pkg::cache_status_t status,
	output logic [`LINE_ADDR_W-1:0]  line_addr
);
	import cache_pkg::*;

	logic [`INDEX_W-1:0] index;
	logic [`TAG_W-1:0]   req_tag;
	logic [1:0]          word_sel;
	logic                tag_match;
	logic                do_write;
	tag_entry_t          tag_rd;
	tag_entry_t          tag_wr;
	line_t               line_rd;
	line_t               line_wr;

	assign index     = addr[`OFFSET_W +: `INDEX_W];
	assign req_tag   = addr[`ADDR_W-1 -: `TAG_W];
	assign word_sel  = ctrl.offset[2:1]; // Bit 0 is a byte select, ignored
	assign tag_match = (tag_rd.tag == req_tag);

	// Compare writes only land on a valid hit, fill writes always
	assign do_write = ctrl.enable & ctrl.write & (~ctrl.comp | (tag_match & tag_rd.valid));

	assign line_addr = {ctrl.tag_src ? tag_rd.tag : req_tag, index};

	always_comb begin
		status.hit   = ctrl.enable & ctrl.comp & tag_match;
		status.valid = tag_rd.valid;
		status.dirty = tag_rd.dirty;
		status.data  = line_rd[word_sel];
	end

	always_comb begin
		tag_wr  = tag_rd;
		line_wr = line_rd;
		line_wr[word_sel] = ctrl.data_src ? fill_data : data_in; // Merge one word
		if (ctrl.comp) begin
			tag_wr.dirty = 1'b1; // Host write on a hit
		end else begin
			tag_wr.valid = 1'b1; // Fill installs a clean line
			tag_wr.dirty = 1'b0;
			tag_wr.tag   = req_tag;
		end
	end

	line_store #(.entry_t(tag_entry_t), .DEPTH(1 << `INDEX_W)) tag_store_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (do_write),
		.waddr (index),
		.raddr (index),
		.wdata (tag_wr),
		.rdata (tag_rd)
	);

	line_store #(.entry_t(line_t), .DEPTH(1 << `INDEX_W)) data_store_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (do_write),
		.waddr (index),
		.raddr (index),
		.wdata (line_wr),
		.rdata (line_rd)
	);

endmodule

/* src/line_store.sv */
module line_store #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 256
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	input  entry_t                   wdata,
	output entry_t                   rdata
);
	entry_t mem [DEPTH];

	assign rdata = mem[raddr]; // Combinational read

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0; // Cold cache after reset
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

endmodule

/* src/mem_pkg.sv */
`include "cache_settings.svh"

package mem_pkg;

	localparam int NUM_BANKS = 4; // One bank per word of a line

	// Command from the controller, the line address comes from the array
	typedef struct packed {
		logic                 wr;
		logic                 rd;
		logic [`OFFSET_W-1:0] offset; // Bits 2:1 pick the bank
	} mem_cmd_t;

endpackage

/* src/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

	// Controller to array
	typedef struct packed {
		logic                enable;
		logic                comp;     // Tag compare access
		logic                write;
		logic [`OFFSET_W-1:0] offset;  // Word select in bits 2:1
		logic                tag_src;  // Stored tag drives line address
		logic                data_src; // Fill data instead of host data
	} cache_ctrl_t;

	// Array to controller and top
	typedef struct packed {
		logic               hit;
		logic               valid;
		logic               dirty;
		logic [`WORD_W-1:0] data;
	} cache_status_t;

	typedef struct packed {
		logic              valid;
		logic              dirty;
		logic [`TAG_W-1:0] tag;
	} tag_entry_t;

	typedef logic [`WORDS_PER_LINE-1:0][`WORD_W-1:0] line_t;

	typedef enum logic [3:0] {
		S_IDLE     = 4'd0,
		S_CMP_RD   = 4'd1,
		S_CMP_WR   = 4'd2,
		S_ACC_RD0  = 4'd3,  // Writeback of the victim line
		S_ACC_RD1  = 4'd4,
		S_ACC_RD2  = 4'd5,
		S_ACC_RD3  = 4'd6,
		S_REQ0     = 4'd7,  // Fill requests
		S_REQ1     = 4'd8,
		S_REQ2_WR0 = 4'd9,  // Requests overlap the first fill writes
		S_REQ3_WR1 = 4'd10,
		S_ACC_WR2  = 4'd11,
		S_ACC_WR3  = 4'd12,
		S_DONE     = 4'd13
	} ctrl_state_t;

endpackage

/* src/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Address and data geometry
`define ADDR_W         16 // Byte address
`define WORD_W         16 // One data word
`define INDEX_W        8  // 256 lines
`define TAG_W          5  // Address bits 15:11
`define OFFSET_W       3  // Byte offset in a line, bit 0 ignored

`define WORDS_PER_LINE 4
`define LINE_ADDR_W    (`TAG_W + `INDEX_W) // Tag joined with index

// Main memory
`define MEM_LATENCY    2       // Read request to data, in cycles
`define MEM_INIT_KEY   16'hA5A5 // Initial word is byte address XOR this

`endif
